// File: Makefile
# Verilator build and run for the immediate pipeline.

VERILATOR ?= verilator
TOP       ?= immPipeTb
FILELIST  ?= immPipe.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := immPipe_config.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(abspath $(SIM_BIN)) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: formatDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "immPipe_config.svh"

module formatDecoder import immPipePkg::*; (
    input  wire logic                  clk,
    input  wire logic                  arstN,
    input  wire logic                  inValid,
    input  wire logic [`IMM_ILEN-1:0]  instr,
    input  wire logic [`IMM_XLEN-1:0]  pc,
    immStageIf.sender                  out
);

    instrWordU  inWord;
    immFormatE  formatNext;

    assign inWord = instr;

    // opcode to format.
    always_comb begin
        case (inWord.iFmt.opcode)
            `IMM_OP_LOAD,
            `IMM_OP_OPIMM,
            `IMM_OP_OPIMM32,
            `IMM_OP_JALR: begin
                formatNext = FMT_I;
            end
            `IMM_OP_STORE: begin
                formatNext = FMT_S;
            end
            `IMM_OP_BRANCH: begin
                formatNext = FMT_B;
            end
            `IMM_OP_LUI,
            `IMM_OP_AUIPC: begin
                formatNext = FMT_U;
            end
            `IMM_OP_JAL: begin
                formatNext = FMT_J;
            end
            // r-type, system, fence and anything unknown.
            default: begin
                formatNext = FMT_NONE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            out.valid  <= 1'b0;
            out.word   <= '0;
            out.pc     <= '0;
            out.format <= FMT_NONE;
        end else begin
            out.valid  <= inValid;
            out.word   <= inWord;
            out.pc     <= pc;
            out.format <= formatNext;
        end
    end

    // immediate is built in the next stage.
    assign out.imm = '0;

    // a strobed word must be fully known.
    assert property (@(posedge clk) disable iff (!arstN)
        inValid |-> !$isunknown(instr));

endmodule

`default_nettype wire

// File: immExtractor.sv
`timescale 1ns/1ps
`default_nettype none

`include "immPipe_config.svh"

module immExtractor import immPipePkg::*; (
    input  wire logic    clk,
    input  wire logic    arstN,
    immStageIf.receiver  in,
    immStageIf.sender    out
);

    logic                  signBit;
    logic [`IMM_XLEN-1:0]  immNext;

    // every format keeps its sign in bit 31.
    assign signBit = in.word.raw[31];

    always_comb begin
        case (in.format)
            FMT_I: begin
                immNext = {{(`IMM_XLEN-12){signBit}}, in.word.iFmt.imm11to0};
            end
            FMT_S: begin
                immNext = {{(`IMM_XLEN-12){signBit}},
                           in.word.sFmt.imm11to5,
                           in.word.sFmt.imm4to0};
            end
            FMT_B: begin
                immNext = {{(`IMM_XLEN-13){signBit}},
                           in.word.bFmt.imm12,
                           in.word.bFmt.imm11,
                           in.word.bFmt.imm10to5,
                           in.word.bFmt.imm4to1,
                           1'b0};
            end
            FMT_U: begin
                immNext = {{(`IMM_XLEN-32){signBit}},
                           in.word.uFmt.imm31to12,
                           12'b0};
            end
            FMT_J: begin
                immNext = {{(`IMM_XLEN-21){signBit}},
                           in.word.jFmt.imm20,
                           in.word.jFmt.imm19to12,
                           in.word.jFmt.imm11,
                           in.word.jFmt.imm10to1,
                           1'b0};
            end
            default: begin
                immNext = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            out.valid  <= 1'b0;
            out.word   <= '0;
            out.pc     <= '0;
            out.format <= FMT_NONE;
            out.imm    <= '0;
        end else begin
            out.valid  <= in.valid;
            out.word   <= in.word;
            out.pc     <= in.pc;
            out.format <= in.format;
            out.imm    <= immNext;
        end
    end

    // upper immediates are page aligned.
    assert property (@(posedge clk) disable iff (!arstN)
        (out.valid && out.format == FMT_U) |-> (out.imm[11:0] == 12'b0));

    // branch and jump offsets are halfword aligned.
    assert property (@(posedge clk) disable iff (!arstN)
        (out.valid && (out.format == FMT_B || out.format == FMT_J)) |-> !out.imm[0]);

endmodule

`default_nettype wire

// File: immPipe.f
+incdir+.
immPipePkg.sv
immStageIf.sv
formatDecoder.sv
immExtractor.sv
targetAdder.sv
immPipeTop.sv
immPipeTb.sv

// File: immPipePkg.sv
`default_nettype none

`include "immPipe_config.svh"

package immPipePkg;

    // instruction format, as recognized from the opcode.
    typedef enum logic [2:0] {
        FMT_NONE = 3'd0,
        FMT_I    = 3'd1,
        FMT_S    = 3'd2,
        FMT_B    = 3'd3,
        FMT_U    = 3'd4,
        FMT_J    = 3'd5
    } immFormatE;

    typedef struct packed {
        logic [11:0] imm11to0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFieldsS;

    typedef struct packed {
        logic [6:0]  imm11to5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm4to0;
        logic [6:0]  opcode;
    } sFieldsS;

    // branch offset bits are scattered across the word.
    typedef struct packed {
        logic        imm12;
        logic [5:0]  imm10to5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [3:0]  imm4to1;
        logic        imm11;
        logic [6:0]  opcode;
    } bFieldsS;

    typedef struct packed {
        logic [19:0] imm31to12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFieldsS;

    typedef struct packed {
        logic        imm20;
        logic [9:0]  imm10to1;
        logic        imm11;
        logic [7:0]  imm19to12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } jFieldsS;

    // one instruction word, viewed per format.
    typedef union packed {
        iFieldsS               iFmt;
        sFieldsS               sFmt;
        bFieldsS               bFmt;
        uFieldsS               uFmt;
        jFieldsS               jFmt;
        logic [`IMM_ILEN-1:0]  raw;
    } instrWordU;

    // branches, jal and auipc produce a pc-relative target.
    function automatic logic immPcRelative(immFormatE fmt, logic [6:0] opcode);
        return (fmt == FMT_B) || (fmt == FMT_J) ||
               ((fmt == FMT_U) && (opcode == `IMM_OP_AUIPC));
    endfunction

endpackage

`default_nettype wire

// File: immPipeTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "immPipe_config.svh"

module immPipeTb import immPipePkg::*; ();

    localparam int ITEM_COUNT = 2000;
    localparam int STIM_CYCLE_LIMIT = 10000;
    localparam int DRAIN_TIMEOUT = 20;
    localparam logic [31:0] LATENCY = 32'd3;

    // one expected output tagged with the negedge count of its input.
    typedef struct packed {
        logic [31:0]           tag;
        immFormatE             format;
        logic [`IMM_XLEN-1:0]  imm;
        logic [`IMM_XLEN-1:0]  target;
        logic                  targetValid;
    } expItemS;

    logic                  clk = 1'b0;
    logic                  arstN;
    logic                  inValid;
    logic [`IMM_ILEN-1:0]  instr;
    logic [`IMM_XLEN-1:0]  pc;
    logic                  outValid;
    immFormatE             outFormat;
    logic [`IMM_XLEN-1:0]  outImm;
    logic [`IMM_XLEN-1:0]  outTarget;
    logic                  outTargetValid;

    logic [31:0]  lcgState;
    logic [31:0]  negCount;
    logic [5:0]   formatSeen;
    expItemS      expQ[$];

    immPipeTop dut_i (
        .clk            (clk),
        .arstN          (arstN),
        .inValid        (inValid),
        .instr          (instr),
        .pc             (pc),
        .outValid       (outValid),
        .outFormat      (outFormat),
        .outImm         (outImm),
        .outTarget      (outTarget),
        .outTargetValid (outTargetValid)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // random bits come from the upper half since the low lcg bits repeat quickly.
    function automatic logic [15:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31:16];
    endfunction

    function automatic logic [6:0] pickOpcode(logic [15:0] r);
        case (r[3:0])
            4'd0:    return `IMM_OP_LOAD;
            4'd1:    return `IMM_OP_OPIMM;
            4'd2:    return `IMM_OP_OPIMM32;
            4'd3:    return `IMM_OP_JALR;
            4'd4:    return `IMM_OP_STORE;
            4'd5:    return `IMM_OP_BRANCH;
            4'd6:    return `IMM_OP_LUI;
            4'd7:    return `IMM_OP_AUIPC;
            4'd8:    return `IMM_OP_JAL;
            4'd9:    return 7'b0110011;
            4'd10:   return 7'b1110011;
            4'd11:   return 7'b0001111;
            default: return r[10:4];
        endcase
    endfunction

    function automatic immFormatE modelFormat(logic [6:0] op);
        if (op == `IMM_OP_LOAD || op == `IMM_OP_OPIMM || op == `IMM_OP_OPIMM32 ||
            op == `IMM_OP_JALR) begin
            return FMT_I;
        end
        if (op == `IMM_OP_STORE) return FMT_S;
        if (op == `IMM_OP_BRANCH) return FMT_B;
        if (op == `IMM_OP_LUI || op == `IMM_OP_AUIPC) return FMT_U;
        if (op == `IMM_OP_JAL) return FMT_J;
        return FMT_NONE;
    endfunction

    function automatic logic [`IMM_XLEN-1:0] modelImm(instrWordU w, immFormatE f);
        logic [31:0] b;
        b = w.raw;
        case (f)
            FMT_I:   return {{52{b[31]}}, b[31:20]};
            FMT_S:   return {{52{b[31]}}, b[31:25], b[11:7]};
            FMT_B:   return {{51{b[31]}}, b[31], b[7], b[30:25], b[11:8], 1'b0};
            FMT_U:   return {{32{b[31]}}, b[31:12], 12'b0};
            FMT_J:   return {{43{b[31]}}, b[31], b[19:12], b[20], b[30:21], 1'b0};
            default: return '0;
        endcase
    endfunction

    // jalr needs a register base, so only branch, jal and auipc qualify.
    function automatic logic modelRelative(logic [6:0] op);
        return (op == `IMM_OP_BRANCH) || (op == `IMM_OP_JAL) || (op == `IMM_OP_AUIPC);
    endfunction

    task automatic stopRun();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic reportMismatch(string testName, logic [63:0] expected, logic [63:0] actual);
        $display("Error: %s expected 0x%h actual 0x%h", testName, expected, actual);
        stopRun();
    endtask

    task automatic reportFailure(string what);
        $display("%s", what);
        stopRun();
    endtask

    // scoreboard runs at the falling edge where outputs are stable.
    always @(negedge clk) begin
        expItemS head;
        expItemS item;
        negCount = negCount + 32'd1;
        if (!arstN) begin
            assert (!outValid && !outTargetValid)
            else reportFailure("output valid raised while reset was asserted");
        end
        assert (!outTargetValid || outValid)
        else reportFailure("target valid raised without output valid");
        if (outValid) begin
            assert (expQ.size() != 0)
            else reportFailure("output valid with no item in flight");
            head = expQ.pop_front();
            assert (head.tag + LATENCY == negCount)
            else reportMismatch("latency", 64'(head.tag + LATENCY), 64'(negCount));
            assert (outFormat == head.format)
            else reportMismatch("format", 64'(head.format), 64'(outFormat));
            assert (outImm == head.imm)
            else reportMismatch("immediate", head.imm, outImm);
            assert (outTargetValid == head.targetValid)
            else reportMismatch("targetValid", 64'(head.targetValid), 64'(outTargetValid));
            assert (outTarget == head.target)
            else reportMismatch("target", head.target, outTarget);
        end else begin
            assert (expQ.size() == 0 || expQ[0].tag + LATENCY != negCount)
            else reportFailure("item missing at its expected output cycle");
        end
        if (arstN && inValid) begin
            item.tag = negCount;
            item.format = modelFormat(instr[6:0]);
            item.imm = modelImm(instr, item.format);
            item.targetValid = modelRelative(instr[6:0]);
            item.target = item.targetValid ? pc + item.imm : '0;
            formatSeen[item.format] = 1'b1;
            expQ.push_back(item);
        end
    end

    initial begin
        int sent;
        int cycle;
        int waitCount;
        logic [15:0] vRand;
        logic [15:0] hiWord;
        logic [15:0] loWord;
        logic [6:0] opcode;
        logic [63:0] pcRand;
        lcgState = 32'h7989_1dd0;
        negCount = '0;
        formatSeen = '0;
        arstN = 1'b0;
        inValid = 1'b0;
        instr = '0;
        pc = '0;
        sent = 0;
        repeat (10) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        // about three in four cycles carry a random item.
        for (cycle = 0; cycle < STIM_CYCLE_LIMIT && sent < ITEM_COUNT; cycle++) begin
            @(posedge clk);
            vRand = nextRandom();
            hiWord = nextRandom();
            loWord = nextRandom();
            opcode = pickOpcode(nextRandom());
            pcRand[63:48] = nextRandom();
            pcRand[47:32] = nextRandom();
            pcRand[31:16] = nextRandom();
            pcRand[15:0] = nextRandom();
            inValid <= (vRand[1:0] != 2'b00);
            instr <= {hiWord, loWord[15:7], opcode};
            pc <= pcRand;
            if (vRand[1:0] != 2'b00) begin
                sent++;
            end
        end
        @(posedge clk);
        inValid <= 1'b0;
        assert (sent == ITEM_COUNT)
        else reportFailure("stimulus loop ran out of cycles before all items were sent");
        waitCount = 0;
        while (expQ.size() != 0 && waitCount < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waitCount++;
        end
        assert (formatSeen == 6'b111111)
        else reportFailure("not every instruction format was exercised");
        if (expQ.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            reportFailure("timed out waiting for the pipeline to drain");
        end
    end

endmodule

`default_nettype wire

// File: immPipeTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "immPipe_config.svh"

module immPipeTop import immPipePkg::*; (
    input  wire logic                  clk,
    input  wire logic                  arstN,
    input  wire logic                  inValid,
    input  wire logic [`IMM_ILEN-1:0]  instr,
    input  wire logic [`IMM_XLEN-1:0]  pc,
    output logic                       outValid,
    output immFormatE                  outFormat,
    output logic [`IMM_XLEN-1:0]       outImm,
    output logic [`IMM_XLEN-1:0]       outTarget,
    output logic                       outTargetValid
);

    // stage links.
    immStageIf s1to2 ();
    immStageIf s2to3 ();

    formatDecoder formatDecoder_i (
        .clk     (clk),
        .arstN   (arstN),
        .inValid (inValid),
        .instr   (instr),
        .pc      (pc),
        .out     (s1to2.sender)
    );

    immExtractor immExtractor_i (
        .clk   (clk),
        .arstN (arstN),
        .in    (s1to2.receiver),
        .out   (s2to3.sender)
    );

    targetAdder targetAdder_i (
        .clk            (clk),
        .arstN          (arstN),
        .in             (s2to3.receiver),
        .outValid       (outValid),
        .outFormat      (outFormat),
        .outImm         (outImm),
        .outTarget      (outTarget),
        .outTargetValid (outTargetValid)
    );

endmodule

`default_nettype wire

// File: immPipe_config.svh
`ifndef IMM_PIPE_CONFIG_SVH
`define IMM_PIPE_CONFIG_SVH

// instruction and data widths.
`define IMM_ILEN 32
`define IMM_XLEN 64

// base opcodes, bits 6:0 of the instruction.
`define IMM_OP_LOAD    7'b0000011
`define IMM_OP_OPIMM   7'b0010011
`define IMM_OP_OPIMM32 7'b0011011
`define IMM_OP_JALR    7'b1100111
`define IMM_OP_STORE   7'b0100011
`define IMM_OP_BRANCH  7'b1100011
`define IMM_OP_LUI     7'b0110111
`define IMM_OP_AUIPC   7'b0010111
`define IMM_OP_JAL     7'b1101111

`endif

// File: immStageIf.sv
`timescale 1ns/1ps
`default_nettype none

`include "immPipe_config.svh"

interface immStageIf import immPipePkg::*; ();

    logic                  valid;
    instrWordU             word;
    logic [`IMM_XLEN-1:0]  pc;
    immFormatE             format;
    // only meaningful once the extractor has run.
    logic [`IMM_XLEN-1:0]  imm;

    modport sender (
        output valid,
        output word,
        output pc,
        output format,
        output imm
    );

    modport receiver (
        input valid,
        input word,
        input pc,
        input format,
        input imm
    );

endinterface

`default_nettype wire

// File: targetAdder.sv
`timescale 1ns/1ps
`default_nettype none

`include "immPipe_config.svh"

module targetAdder import immPipePkg::*; (
    input  wire logic                  clk,
    input  wire logic                  arstN,
    immStageIf.receiver                in,
    output logic                       outValid,
    output immFormatE                  outFormat,
    output logic [`IMM_XLEN-1:0]       outImm,
    output logic [`IMM_XLEN-1:0]       outTarget,
    output logic                       outTargetValid
);

    logic                  isRelative;
    logic [`IMM_XLEN-1:0]  targetSum;

    // wraps modulo 2^64.
    assign targetSum  = in.pc + in.imm;
    assign isRelative = immPcRelative(in.format, in.word.raw[6:0]);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid       <= 1'b0;
            outFormat      <= FMT_NONE;
            outImm         <= '0;
            outTarget      <= '0;
            outTargetValid <= 1'b0;
        end else begin
            outValid       <= in.valid;
            outFormat      <= in.format;
            outImm         <= in.imm;
            outTargetValid <= in.valid && isRelative;
            // jalr lands here too, its base is a register.
            if (isRelative) begin
                outTarget <= targetSum;
            end else begin
                outTarget <= '0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arstN)
        outTargetValid |-> outValid);

endmodule

`default_nettype wire
